// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // field widths of the 32-bit instruction word
    localparam int ILEN      = 32;
    localparam int OPCODE_W  = 5;
    localparam int REG_SEL_W = 5;
    localparam int IMM_W     = 17;
    localparam int COND_W    = 2;

    // opcodes
    localparam logic [OPCODE_W-1:0] OP_NOP  = 5'd0;
    localparam logic [OPCODE_W-1:0] OP_ADD  = 5'd1;
    localparam logic [OPCODE_W-1:0] OP_SUB  = 5'd2;
    localparam logic [OPCODE_W-1:0] OP_AND  = 5'd3;
    localparam logic [OPCODE_W-1:0] OP_OR   = 5'd4;
    localparam logic [OPCODE_W-1:0] OP_XOR  = 5'd5;
    localparam logic [OPCODE_W-1:0] OP_ADDI = 5'd6;
    localparam logic [OPCODE_W-1:0] OP_BR   = 5'd7;
    localparam logic [OPCODE_W-1:0] OP_JMP  = 5'd8;

    // branch conditions, held in the low bits of rd
    localparam logic [COND_W-1:0] COND_EQ = 2'd0;
    localparam logic [COND_W-1:0] COND_NE = 2'd1;
    localparam logic [COND_W-1:0] COND_MI = 2'd2;
    localparam logic [COND_W-1:0] COND_PL = 2'd3;

    // one word, two views
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0]                  opcode;
            logic [REG_SEL_W-1:0]                 rd;
            logic [REG_SEL_W-1:0]                 rs1;
            logic [REG_SEL_W-1:0]                 rs2;
            logic [ILEN-OPCODE_W-3*REG_SEL_W-1:0] spare;
        } r;
        struct packed {
            logic [OPCODE_W-1:0]     opcode;
            logic [REG_SEL_W-1:0]    rd;
            logic [REG_SEL_W-1:0]    rs1;
            logic signed [IMM_W-1:0] imm;
        } i;
    } instr_t;

endpackage

`default_nettype wire

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

    // data path width
    localparam int XLEN = 32;

    // register file depth, r0 included
    localparam int NUM_REGS = 32;

    // flag register bit positions
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;

endpackage

`default_nettype wire

// File: design/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
    import isa_pkg::*;
    import core_pkg::*;

    // slot holds a real instruction
    logic                 valid;
    logic [OPCODE_W-1:0]  op;
    logic [REG_SEL_W-1:0] rd;
    // source selectors kept for forwarding
    logic [REG_SEL_W-1:0] rs1_sel;
    logic [REG_SEL_W-1:0] rs2_sel;
    // register values read in decode
    logic [XLEN-1:0]      a;
    logic [XLEN-1:0]      b;
    // sign extended immediate
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      pc;

    modport producer (output valid, op, rd, rs1_sel, rs2_sel, a, b, imm, pc);
    modport consumer (input valid, op, rd, rs1_sel, rs2_sel, a, b, imm, pc);

endinterface

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      redirect,
    input  logic [core_pkg::XLEN-1:0] redirect_pc,
    input  logic                      instr_valid,
    input  logic [31:0]               instr_data,
    output logic                      instr_rd,
    output logic [core_pkg::XLEN-1:0] instr_addr,
    output logic                      fd_valid,
    output logic [31:0]               fd_instr,
    output logic [core_pkg::XLEN-1:0] fd_pc
);
    import core_pkg::*;

    // word address of the next request
    logic [XLEN-1:0] pc;
    // outstanding fetch belongs to a flushed path
    logic            discard;
    logic            done;
    logic            issue;
    logic [XLEN-1:0] next_addr;

    assign done      = instr_rd && instr_valid;
    // free to start a new request
    assign issue     = !instr_rd || done;
    assign next_addr = redirect ? redirect_pc : pc;

    //////////////////////////////////////////////////
    // request side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            discard  <= 1'b0;
            instr_rd <= 1'b0;
            fd_valid <= 1'b0;
        end else begin
            if (issue) begin
                instr_rd   <= 1'b1;
                instr_addr <= next_addr;
                pc         <= next_addr + XLEN'(1);
                discard    <= 1'b0;
            end else if (redirect) begin
                // old request still in flight, drop it on return
                pc      <= redirect_pc;
                discard <= 1'b1;
            end
            // stale or wrong-path data never enters decode
            fd_valid <= done && !discard && !redirect;
        end
    end

    //////////////////////////////////////////////////
    // fetch/decode register payload
    always_ff @(posedge clk) begin
        if (done) begin
            fd_instr <= instr_data;
            fd_pc    <= instr_addr;
        end
    end

    // memory sees one address per request
    a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
        instr_rd && !instr_valid |=> instr_rd && $stable(instr_addr));

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [isa_pkg::REG_SEL_W-1:0] rs1_sel,
    input  logic [isa_pkg::REG_SEL_W-1:0] rs2_sel,
    input  logic                         wb_valid,
    input  logic [isa_pkg::REG_SEL_W-1:0] wb_sel,
    input  logic [core_pkg::XLEN-1:0]    wb_data,
    output logic [core_pkg::XLEN-1:0]    rs1_data,
    output logic [core_pkg::XLEN-1:0]    rs2_data
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            we;

    // r0 is never stored, no writes while in reset
    assign we = rst_n && wb_valid && (wb_sel != '0);

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wb_sel] <= wb_data;
        end
    end

    // write-through covers the instruction two ahead
    assign rs1_data = (rs1_sel == '0) ? '0 :
                      (we && wb_sel == rs1_sel) ? wb_data : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 :
                      (we && wb_sel == rs2_sel) ? wb_data : regs[rs2_sel];

endmodule

`default_nettype wire

// File: design/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          fd_valid,
    input  logic [31:0]                   fd_instr,
    input  logic [core_pkg::XLEN-1:0]     fd_pc,
    input  logic                          redirect,
    input  logic                          wb_valid,
    input  logic [isa_pkg::REG_SEL_W-1:0] wb_sel,
    input  logic [core_pkg::XLEN-1:0]     wb_data,
    decode_if.producer                    de
);
    import isa_pkg::*;
    import core_pkg::*;

    instr_t               ins;
    logic [OPCODE_W-1:0]  op;
    logic [REG_SEL_W-1:0] rs1_sel;
    logic [REG_SEL_W-1:0] rs2_sel;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [XLEN-1:0]      imm_ext;
    logic [XLEN-1:0]      imm_sx;

    assign ins    = fd_instr;
    assign imm_sx = {{(XLEN-IMM_W){ins.i.imm[IMM_W-1]}}, ins.i.imm};

    //////////////////////////////////////////////////
    // field decode
    always_comb begin
        op      = ins.r.opcode;
        rs1_sel = '0;
        rs2_sel = '0;
        imm_ext = '0;
        case (ins.r.opcode)
            // register view
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                rs1_sel = ins.r.rs1;
                rs2_sel = ins.r.rs2;
            end
            // immediate view
            OP_ADDI: begin
                rs1_sel = ins.i.rs1;
                imm_ext = imm_sx;
            end
            // offset only, rd carries the condition
            OP_BR, OP_JMP: begin
                imm_ext = imm_sx;
            end
            OP_NOP: begin
            end
            // unknown opcode runs as a bubble
            default: begin
                op = OP_NOP;
            end
        endcase
    end

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .wb_valid (wb_valid),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    //////////////////////////////////////////////////
    // decode/execute register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de.valid <= 1'b0;
        end else begin
            // younger slot dies with a taken branch
            de.valid <= fd_valid && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (fd_valid) begin
            de.op      <= op;
            de.rd      <= ins.r.rd;
            de.rs1_sel <= rs1_sel;
            de.rs2_sel <= rs2_sel;
            de.a       <= rs1_data;
            de.b       <= rs2_data;
            de.imm     <= imm_ext;
            de.pc      <= fd_pc;
        end
    end

endmodule

`default_nettype wire

// File: design/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    decode_if.consumer                    de,
    output logic                          redirect,
    output logic [core_pkg::XLEN-1:0]     redirect_pc,
    output logic                          wb_valid,
    output logic [isa_pkg::REG_SEL_W-1:0] wb_sel,
    output logic [core_pkg::XLEN-1:0]     wb_data
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   alu_out;
    logic              is_alu;
    // N and Z
    logic [1:0]        flags;
    logic [COND_W-1:0] cond;
    logic              cond_met;
    logic              taken;

    //////////////////////////////////////////////////
    // forwarding from the execute/writeback register
    assign op_a = (wb_valid && wb_sel != '0 && wb_sel == de.rs1_sel) ? wb_data : de.a;
    assign op_b = (wb_valid && wb_sel != '0 && wb_sel == de.rs2_sel) ? wb_data : de.b;

    // alu
    always_comb begin
        is_alu  = 1'b1;
        alu_out = '0;
        case (de.op)
            OP_ADD:  alu_out = op_a + op_b;
            OP_SUB:  alu_out = op_a - op_b;
            OP_AND:  alu_out = op_a & op_b;
            OP_OR:   alu_out = op_a | op_b;
            OP_XOR:  alu_out = op_a ^ op_b;
            OP_ADDI: alu_out = op_a + de.imm;
            default: is_alu = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // branch resolution against the flag register
    assign cond = de.rd[COND_W-1:0];

    always_comb begin
        cond_met = 1'b0;
        case (cond)
            COND_EQ: cond_met = flags[FLAG_Z];
            COND_NE: cond_met = !flags[FLAG_Z];
            COND_MI: cond_met = flags[FLAG_N];
            COND_PL: cond_met = !flags[FLAG_N];
            default: cond_met = 1'b0;
        endcase
    end

    assign taken       = (de.op == OP_JMP) || (de.op == OP_BR && cond_met);
    assign redirect    = de.valid && taken;
    // target relative to the next word
    assign redirect_pc = de.pc + XLEN'(1) + de.imm;

    // flags and writeback valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags    <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= de.valid && is_alu;
            if (de.valid && is_alu) begin
                flags[FLAG_N] <= alu_out[XLEN-1];
                flags[FLAG_Z] <= (alu_out == '0);
            end
        end
    end

    // writeback payload
    always_ff @(posedge clk) begin
        if (de.valid) begin
            wb_sel  <= de.rd;
            wb_data <= alu_out;
        end
    end

    // a taken slot is real, and decode empties the slot behind it
    a_redirect_flush : assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> de.valid ##1 (!de.valid && !redirect));

endmodule

`default_nettype wire

// File: design/pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_valid,
    input  logic [31:0]                   instr_data,
    output logic                          instr_rd,
    output logic [core_pkg::XLEN-1:0]     instr_addr,
    output logic                          wb_valid,
    output logic [isa_pkg::REG_SEL_W-1:0] wb_sel,
    output logic [core_pkg::XLEN-1:0]     wb_data
);
    import core_pkg::*;

    // redirect from execute
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    // fetch/decode register
    logic            fd_valid;
    logic [31:0]     fd_instr;
    logic [XLEN-1:0] fd_pc;

    decode_if de_bus ();

    //////////////////////////////////////////////////
    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .instr_rd    (instr_rd),
        .instr_addr  (instr_addr),
        .fd_valid    (fd_valid),
        .fd_instr    (fd_instr),
        .fd_pc       (fd_pc)
    );

    decode_unit u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .fd_valid (fd_valid),
        .fd_instr (fd_instr),
        .fd_pc    (fd_pc),
        .redirect (redirect),
        .wb_valid (wb_valid),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data),
        .de       (de_bus)
    );

    execute_unit u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .de          (de_bus),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_valid    (wb_valid),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// expected register writes in retire order, selector and data
logic [4:0]  exp_sel  [64];
logic [31:0] exp_data [64];
int          exp_n;

//////////////////////////////////////////////////
// instruction encoders
function automatic logic [31:0] enc_reg(input logic [4:0] op, input int rd,
                                        input int rs1, input int rs2);
    return {op, rd[4:0], rs1[4:0], rs2[4:0], 12'd0};
endfunction

function automatic logic [31:0] enc_imm(input logic [4:0] op, input int rd,
                                        input int rs1, input int imm);
    return {op, rd[4:0], rs1[4:0], imm[16:0]};
endfunction

// condition sits in the low bits of rd
function automatic logic [31:0] enc_br(input logic [1:0] cond, input int off);
    return {OP_BR, 3'b000, cond, 5'd0, off[16:0]};
endfunction

function automatic logic [31:0] enc_jmp(input int off);
    return {OP_JMP, 10'd0, off[16:0]};
endfunction

//////////////////////////////////////////////////
// test program, word addressed from zero
function automatic logic [31:0] prog_word(input logic [31:0] addr);
    logic [31:0] w;
    case (addr)
        // dependent chain at distances one and two
        0:  w = enc_imm(OP_ADDI, 1, 0, 5);
        1:  w = enc_imm(OP_ADDI, 2, 1, 3);
        2:  w = enc_reg(OP_ADD, 3, 1, 2);
        3:  w = enc_reg(OP_SUB, 4, 3, 1);
        4:  w = enc_reg(OP_XOR, 5, 4, 3);
        5:  w = enc_reg(OP_SUB, 6, 5, 1);
        // Z set, EQ taken
        6:  w = enc_br(COND_EQ, 1);
        7:  w = enc_imm(OP_ADDI, 7, 0, 99);
        // branches keep the flags, NE falls through
        8:  w = enc_br(COND_NE, 1);
        9:  w = enc_imm(OP_ADDI, 8, 0, -4);
        10: w = enc_br(COND_MI, 1);
        11: w = enc_imm(OP_ADDI, 9, 0, 77);
        12: w = enc_br(COND_PL, 1);
        13: w = enc_reg(OP_AND, 10, 8, 2);
        14: w = enc_br(COND_PL, 1);
        15: w = enc_imm(OP_ADDI, 11, 0, 55);
        16: w = enc_br(COND_EQ, 1);
        17: w = enc_br(COND_NE, 1);
        18: w = enc_imm(OP_ADDI, 12, 0, 66);
        // r0 write retires, later reads still see zero
        19: w = enc_imm(OP_ADDI, 0, 1, 100);
        20: w = enc_reg(OP_OR, 13, 0, 1);
        21: w = enc_reg(OP_ADD, 14, 0, 0);
        22: w = enc_jmp(2);
        23: w = enc_imm(OP_ADDI, 15, 0, 11);
        24: w = enc_imm(OP_ADDI, 16, 0, 12);
        25: w = enc_imm(OP_ADDI, 17, 14, -1);
        // parks here
        26: w = enc_jmp(-1);
        // visible write to r31 if a wrong-path word ever retires
        default: w = {OP_ADDI, 5'd31, 5'd0, addr[16:0] ^ {2'b00, addr[31:17]}};
    endcase
    return w;
endfunction

//////////////////////////////////////////////////
// sequential model, one instruction per step
task automatic build_expected();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [4:0]  op;
    logic        writes;
    logic        take;
    logic        z;
    logic        n;
    logic        halt;
    int          step;
    regs  = '{default: '0};
    pc    = '0;
    z     = 1'b0;
    n     = 1'b0;
    halt  = 1'b0;
    exp_n = 0;
    for (step = 0; step < 200 && !halt; step++) begin
        w      = prog_word(pc);
        op     = w[31:27];
        a      = regs[w[21:17]];
        b      = regs[w[16:12]];
        imm    = {{15{w[16]}}, w[16:0]};
        writes = 1'b1;
        take   = 1'b0;
        res    = '0;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + imm;
            OP_BR: begin
                writes = 1'b0;
                case (w[23:22])
                    COND_EQ: take = z;
                    COND_NE: take = !z;
                    COND_MI: take = n;
                    COND_PL: take = !n;
                endcase
            end
            OP_JMP: begin
                writes = 1'b0;
                take   = 1'b1;
            end
            // nop and unknown opcodes
            default: writes = 1'b0;
        endcase
        if (writes) begin
            exp_sel[exp_n[5:0]]  = w[26:22];
            exp_data[exp_n[5:0]] = res;
            exp_n++;
            if (w[26:22] != 5'd0) begin
                regs[w[26:22]] = res;
            end
            z = (res == 32'd0);
            n = res[31];
        end
        // jump to itself ends the program
        halt = (op == OP_JMP) && (imm == 32'hffff_ffff);
        pc   = take ? pc + 32'd1 + imm : pc + 32'd1;
    end
endtask

`endif

// File: tb/tb_pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_core;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int RETIRE_TIMEOUT = 2000;
    localparam int QUIET_CYCLES   = 60;

    logic                 clk;
    logic                 rst_n;
    logic                 instr_valid;
    logic [31:0]          instr_data;
    logic                 instr_rd;
    logic [XLEN-1:0]      instr_addr;
    logic                 wb_valid;
    logic [REG_SEL_W-1:0] wb_sel;
    logic [XLEN-1:0]      wb_data;

    // posedge count and retired writes
    int          cycles  = 0;
    int          retired = 0;
    logic [31:0] rng     = 32'd55872;

    `include "tb_program.svh"

    pipe_core UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .instr_rd    (instr_rd),
        .instr_addr  (instr_addr),
        .wb_valid    (wb_valid),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n && wb_valid) begin
            retired <= retired + 1;
        end
    end

    //////////////////////////////////////////////////
    // instruction memory, 0 to 3 idle cycles per request
    initial begin : responder
        int wait_n;
        instr_valid = 1'b0;
        instr_data  = '0;
        forever begin
            @(negedge clk);
            instr_valid = 1'b0;
            if (instr_rd === 1'b1) begin
                rng    = xorshift32(rng);
                wait_n = int'(rng[1:0]);
                repeat (wait_n) @(negedge clk);
                instr_data  = prog_word(instr_addr);
                instr_valid = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    // outputs quiet in reset and at the first edge out of it
    reset_quiet : assert property (@(posedge clk)
        ((cycles > 0 && !rst_n) || $rose(rst_n)) |-> (!wb_valid && !instr_rd))
        else fail_run($sformatf(
            "ERROR reset_quiet: expected wb_valid=0 instr_rd=0, actual wb_valid=%b instr_rd=%b",
            $sampled(wb_valid), $sampled(instr_rd)));

    // nothing beyond the model's list, skipped paths included
    retire_extra : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (retired < exp_n))
        else fail_run($sformatf("write to r%0d retired after all %0d expected writes",
            $sampled(wb_sel), exp_n));

    // program order, forwarding and write-through
    retire_data : assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid && retired < exp_n) |->
            (wb_sel == exp_sel[retired[5:0]] && wb_data == exp_data[retired[5:0]]))
        else fail_run($sformatf("ERROR retire_data #%0d: expected r%0d=%h, actual r%0d=%h",
            $sampled(retired), exp_sel[$sampled(retired[5:0])],
            exp_data[$sampled(retired[5:0])], $sampled(wb_sel), $sampled(wb_data)));

    //////////////////////////////////////////////////
    initial begin : main
        int waited;
        rst_n = 1'b0;
        build_expected();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // every expected write, whatever the latency mix
        waited = 0;
        while (retired < exp_n && waited < RETIRE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (retired < exp_n) begin
            fail_run($sformatf("timed out with %0d of %0d writes retired", retired, exp_n));
        end

        // quiet window, a late write trips retire_extra
        waited = 0;
        while (waited < QUIET_CYCLES) begin
            @(negedge clk);
            waited++;
        end

        if (retired == exp_n) begin
            $display("*** TEST PASSED ***");
        end else begin
            fail_run($sformatf("%0d writes retired, %0d expected", retired, exp_n));
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pipe_core.f
+incdir+tb
design/isa_pkg.sv
design/core_pkg.sv
design/decode_if.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/pipe_core.sv
tb/tb_pipe_core.sv

// File: Makefile
# verilator flow for pipe_core
SIM = obj_dir/Vtb_pipe_core

.PHONY: all run lint clean

all: run

$(SIM): pipe_core.f design/*.sv tb/*.sv tb/*.svh
	verilator --binary --timing --assert --timescale 1ns/1ps -f pipe_core.f \
		--top-module tb_pipe_core -Mdir obj_dir

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f pipe_core.f \
		--top-module tb_pipe_core

clean:
	rm -rf obj_dir sim.log
